//--- arm_isa_pkg.sv
`default_nettype none

package arm_isa_pkg;

	// position of the C flag in the CPSR word
	localparam int cpsr_c_bit = 29;

	typedef enum logic [1:0] {
		sh_lsl = 2'b00,
		sh_lsr = 2'b01,
		sh_asr = 2'b10,
		sh_ror = 2'b11
	} shift_type_t;

	typedef enum logic [4:0] {
		cls_alu, cls_multiply, cls_mrs, cls_msr, cls_msr_flags, cls_swap,
		cls_bx, cls_half_reg, cls_half_imm, cls_single_xfer, cls_block_xfer,
		cls_branch, cls_cop_xfer, cls_cop_op, cls_cop_reg, cls_swi, cls_undefined
	} insn_class_t;

	typedef union packed {
		// data processing layout, also used for the register fields of other classes
		struct packed {
			logic [3:0] cond;
			logic [1:0] class_bits;
			logic imm;
			logic [3:0] opcode;
			logic set_cc;
			logic [3:0] rn;
			logic [3:0] rd;
			logic [4:0] shamt_rs;
			shift_type_t shift_type;
			logic reg_shift;
			logic [3:0] rm;
		} dp;
		struct packed {
			logic [3:0] cond;
			logic [2:0] class_bits;
			logic link;
			logic [23:0] offset;
		} br;
	} insn_word_u;

	// priority order matters, multiply is a special case of the ALU pattern
	function automatic insn_class_t classify_insn(input logic [31:0] w);
		insn_class_t c;
		casez (w)
		32'b????000000??????????????1001????: c = cls_multiply;
		32'b????00010?001111????000000000000: c = cls_mrs;
		32'b????00010?101001111100000000????: c = cls_msr;
		32'b????00?10?1010001111????????????: c = cls_msr_flags;
		32'b????00010?00????????00001001????: c = cls_swap;
		32'b????000100101111111111110001????: c = cls_bx;
		32'b????000??0??????????00001??1????: c = cls_half_reg;
		32'b????000??1??????????????1??1????: c = cls_half_imm;
		32'b????011????????????????????1????: c = cls_undefined;
		32'b????01??????????????????????????: c = cls_single_xfer;
		32'b????100?????????????????????????: c = cls_block_xfer;
		32'b????101?????????????????????????: c = cls_branch;
		32'b????110?????????????????????????: c = cls_cop_xfer;
		32'b????1110???????????????????0????: c = cls_cop_op;
		32'b????1110???????????????????1????: c = cls_cop_reg;
		32'b????1111????????????????????????: c = cls_swi;
		32'b????00??????????????????????????: c = cls_alu;
		default: c = cls_undefined;
		endcase
		return c;
	endfunction

endpackage

`default_nettype wire

//--- arm_core_pkg.sv
`default_nettype none

package arm_core_pkg;

	localparam int word_bits = 32;
	localparam int word_bytes = word_bits / 8;
	localparam int reg_addr_bits = 4;
	localparam int gpr_count = 15;
	localparam logic [reg_addr_bits-1:0] pc_reg = reg_addr_bits'(15);

	localparam int queue_depth = 4;
	localparam int queue_ptr_bits = $clog2(queue_depth);

	// r15 reads back this far behind the stamped PC
	localparam logic [word_bits-1:0] pc_read_offset = word_bits'(8);
	// ALU with a register-specified shift sees one more word of pipeline
	localparam logic [word_bits-1:0] pc_read_offset_rs = word_bits'(12);
	localparam logic [word_bits-1:0] fetch_pc_ahead = word_bits'(8);
	localparam logic [word_bits-1:0] reset_pc = word_bits'(0);

endpackage

`default_nettype wire

//--- pc_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module pc_sequencer (
	input wire clk,
	input wire rst_n,
	input wire insn_strobe,
	input wire [arm_core_pkg::word_bits-1:0] insn_word,
	input wire queue_full,
	output logic push,
	output logic [arm_core_pkg::word_bits-1:0] push_insn,
	output logic [arm_core_pkg::word_bits-1:0] push_pc
);
	import arm_core_pkg::*;

	// byte address of the next word to be accepted
	logic [word_bits-1:0] fetch_addr;

	// a strobe into a full queue is lost and the address stays
	assign push = insn_strobe && !queue_full;
	assign push_insn = insn_word;
	assign push_pc = fetch_addr + fetch_pc_ahead;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			fetch_addr <= reset_pc;
		end else if (push) begin
			fetch_addr <= fetch_addr + word_bits'(word_bytes);
		end
	end

endmodule

`default_nettype wire

//--- insn_queue.sv
`timescale 1ns/100ps
`default_nettype none

module insn_queue (
	input wire clk,
	input wire rst_n,
	input wire push,
	input wire [arm_core_pkg::word_bits-1:0] push_insn,
	input wire [arm_core_pkg::word_bits-1:0] push_pc,
	input wire pop,
	output logic [arm_core_pkg::word_bits-1:0] head_insn,
	output logic [arm_core_pkg::word_bits-1:0] head_pc,
	output logic queue_empty,
	output logic queue_full
);
	import arm_core_pkg::*;

	logic [word_bits-1:0] insn_mem [queue_depth];
	logic [word_bits-1:0] pc_mem [queue_depth];
	logic [queue_ptr_bits-1:0] wr_ptr;
	logic [queue_ptr_bits-1:0] rd_ptr;
	logic [queue_ptr_bits:0] count;
	logic do_push;
	logic do_pop;

	// wraps at queue_depth, which need not be a power of two
	function automatic logic [queue_ptr_bits-1:0] next_ptr(input logic [queue_ptr_bits-1:0] ptr);
		return (ptr == queue_ptr_bits'(queue_depth - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign queue_empty = (count == '0);
	assign queue_full = (count == (queue_ptr_bits + 1)'(queue_depth));
	assign do_pop = pop && !queue_empty;
	// when full, a word can still enter as the head leaves
	assign do_push = push && (!queue_full || do_pop);

	assign head_insn = insn_mem[rd_ptr];
	assign head_pc = pc_mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_push) begin
			insn_mem[wr_ptr] <= push_insn;
			pc_mem[wr_ptr] <= push_pc;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= next_ptr(wr_ptr);
			end
			if (do_pop) begin
				rd_ptr <= next_ptr(rd_ptr);
			end
			case ({do_push, do_pop})
			2'b10: count <= count + 1'b1;
			2'b01: count <= count - 1'b1;
			default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- register_file.sv
`timescale 1ns/100ps
`default_nettype none

module register_file (
	input wire clk,
	input wire wb_strobe,
	input wire [arm_core_pkg::reg_addr_bits-1:0] wb_addr,
	input wire [arm_core_pkg::word_bits-1:0] wb_data,
	input wire [arm_core_pkg::reg_addr_bits-1:0] read_0,
	input wire [arm_core_pkg::reg_addr_bits-1:0] read_1,
	input wire [arm_core_pkg::reg_addr_bits-1:0] read_2,
	output logic [arm_core_pkg::word_bits-1:0] rdata_0,
	output logic [arm_core_pkg::word_bits-1:0] rdata_1,
	output logic [arm_core_pkg::word_bits-1:0] rdata_2
);
	import arm_core_pkg::*;

	// r0 to r14 only, the PC lives in the decoder
	logic [word_bits-1:0] regs [gpr_count];

	always_ff @(posedge clk) begin
		if (wb_strobe && wb_addr != pc_reg) begin
			regs[wb_addr] <= wb_data;
		end
	end

	assign rdata_0 = (read_0 == pc_reg) ? '0 : regs[read_0];
	assign rdata_1 = (read_1 == pc_reg) ? '0 : regs[read_1];
	assign rdata_2 = (read_2 == pc_reg) ? '0 : regs[read_2];

endmodule

`default_nettype wire

//--- operand_shifter.sv
`timescale 1ns/100ps
`default_nettype none

module operand_shifter (
	input wire arm_isa_pkg::insn_word_u insn,
	input wire [arm_core_pkg::word_bits-1:0] operand,
	input wire [arm_core_pkg::word_bits-1:0] reg_amt,
	input wire carry_in,
	output logic [arm_core_pkg::word_bits-1:0] result,
	output logic carry_out
);
	import arm_core_pkg::*;
	import arm_isa_pkg::*;

	logic [5:0] amt;
	logic [word_bits-1:0] rs_value;
	logic rs_carry;
	logic is_arith;
	logic is_rot;
	logic imm_zero;

	assign is_arith = (insn.dp.shift_type == sh_asr);
	assign is_rot = (insn.dp.shift_type == sh_ror);
	assign imm_zero = (insn.dp.shamt_rs == '0);

	// immediate 0 stands for 32 on LSR and ASR
	always_comb begin
		if (insn.dp.reg_shift) begin
			amt = (reg_amt[7:0] > 8'd32) ? 6'd32 : reg_amt[5:0];
		end else begin
			amt = {imm_zero && (is_arith || insn.dp.shift_type == sh_lsr), insn.dp.shamt_rs};
		end
	end

	// stages of 32, 16, 8, 4, 2 and 1, each keeping the last bit shifted out
	always_comb begin
		rs_value = operand;
		rs_carry = carry_in;
		for (int i = 5; i >= 0; i--) begin
			if (amt[i]) begin
				rs_carry = rs_value[(1 << i) - 1];
				if (is_rot) begin
					rs_value = (rs_value >> (1 << i)) | (rs_value << (word_bits - (1 << i)));
				end else if (is_arith) begin
					rs_value = $unsigned($signed(rs_value) >>> (1 << i));
				end else begin
					rs_value = rs_value >> (1 << i);
				end
			end
		end
	end

	always_comb begin
		result = rs_value;
		carry_out = rs_carry;
		if (insn.dp.shift_type == sh_lsl) begin
			{carry_out, result} = {carry_in, operand} << amt;
		end else if (is_rot && !insn.dp.reg_shift && imm_zero) begin
			// RRX rotates the old carry into bit 31
			result = {carry_in, operand[word_bits-1:1]};
			carry_out = operand[0];
		end
	end

endmodule

`default_nettype wire

//--- operand_decode.sv
`timescale 1ns/100ps
`default_nettype none

module operand_decode (
	input wire clk,
	input wire rst_n,
	input wire queue_empty,
	input wire [arm_core_pkg::word_bits-1:0] head_insn,
	input wire [arm_core_pkg::word_bits-1:0] head_pc,
	input wire hold,
	input wire cpsr_carry,
	output logic pop,
	output logic [arm_core_pkg::reg_addr_bits-1:0] read_0,
	output logic [arm_core_pkg::reg_addr_bits-1:0] read_1,
	output logic [arm_core_pkg::reg_addr_bits-1:0] read_2,
	input wire [arm_core_pkg::word_bits-1:0] rdata_0,
	input wire [arm_core_pkg::word_bits-1:0] rdata_1,
	input wire [arm_core_pkg::word_bits-1:0] rdata_2,
	output arm_isa_pkg::insn_word_u shift_insn,
	output logic [arm_core_pkg::word_bits-1:0] shift_operand,
	output logic [arm_core_pkg::word_bits-1:0] shift_amt,
	input wire [arm_core_pkg::word_bits-1:0] shift_result,
	input wire shift_carry,
	output logic [arm_core_pkg::word_bits-1:0] op0,
	output logic [arm_core_pkg::word_bits-1:0] op1,
	output logic [arm_core_pkg::word_bits-1:0] op2,
	output logic carry,
	output arm_isa_pkg::insn_class_t op_class,
	output logic op_valid
);
	import arm_core_pkg::*;
	import arm_isa_pkg::*;

	insn_word_u insn;
	logic [word_bits-1:0] inpc;
	logic insn_valid;
	insn_class_t cls;
	logic [word_bits-1:0] rpc;
	logic [word_bits-1:0] regs0;
	logic [word_bits-1:0] regs1;
	logic [2*word_bits-1:0] rot_pair;
	logic [word_bits-1:0] rot_imm;
	logic [word_bits-1:0] op0_next;
	logic [word_bits-1:0] op1_next;
	logic [word_bits-1:0] op2_next;
	logic carry_next;

	// fetch and operand stages stall together on hold
	assign pop = !queue_empty && !hold;

	always_ff @(posedge clk) begin
		if (pop) begin
			insn <= head_insn;
			inpc <= head_pc;
		end
	end

	assign cls = classify_insn(insn);

	assign rpc = inpc - ((cls == cls_alu && !insn.dp.imm && insn.dp.reg_shift)
		? pc_read_offset_rs : pc_read_offset);
	assign regs0 = (read_0 == pc_reg) ? rpc : rdata_0;
	assign regs1 = (read_1 == pc_reg) ? rpc : rdata_1;

	// 8-bit immediate rotated right by twice the rotate field
	assign rot_pair = {2{word_bits'(insn[7:0])}};
	assign rot_imm = word_bits'(rot_pair >> {insn[11:8], 1'b0});

	assign shift_insn = insn;
	assign shift_operand = regs1;
	assign shift_amt = rdata_2;

	always_comb begin
		read_0 = '0;
		read_1 = '0;
		read_2 = '0;
		case (cls)
		cls_multiply: begin
			// accumulate register sits in the rd slot
			read_0 = insn.dp.rd;
			read_1 = insn.dp.rm;
			read_2 = insn.dp.shamt_rs[4:1];
		end
		cls_alu: begin
			read_0 = insn.dp.rn;
			read_1 = insn.dp.rm;
			read_2 = insn.dp.shamt_rs[4:1];
		end
		cls_swap, cls_half_reg, cls_single_xfer: begin
			read_0 = insn.dp.rn;
			read_1 = insn.dp.rm;
		end
		cls_msr, cls_msr_flags, cls_bx: read_0 = insn.dp.rm;
		cls_half_imm, cls_block_xfer, cls_cop_xfer: read_0 = insn.dp.rn;
		cls_cop_reg: read_0 = insn.dp.rd;
		default: ;
		endcase
	end

	always_comb begin
		op0_next = '0;
		op1_next = '0;
		op2_next = '0;
		carry_next = 1'b0;
		case (cls)
		cls_multiply: begin
			op0_next = regs0;
			op1_next = regs1;
			op2_next = rdata_2;
		end
		cls_alu: begin
			op0_next = regs0;
			op1_next = insn.dp.imm ? rot_imm : shift_result;
			carry_next = insn.dp.imm ? cpsr_carry : shift_carry;
		end
		cls_msr, cls_bx, cls_cop_reg: op0_next = regs0;
		cls_msr_flags: op0_next = insn.dp.imm ? rot_imm : regs0;
		cls_swap, cls_half_reg: begin
			op0_next = regs0;
			op1_next = regs1;
		end
		cls_half_imm: begin
			op0_next = regs0;
			op1_next = word_bits'({insn[11:8], insn[3:0]});
		end
		cls_single_xfer: begin
			// bit 25 set means a shifted register offset here
			op0_next = regs0;
			op1_next = insn.dp.imm ? shift_result : word_bits'(insn[11:0]);
			carry_next = insn.dp.imm ? shift_carry : cpsr_carry;
		end
		cls_block_xfer: begin
			op0_next = regs0;
			op1_next = word_bits'(insn[15:0]);
		end
		cls_branch: op0_next = {{(word_bits-26){insn.br.offset[23]}}, insn.br.offset, 2'b00};
		cls_cop_xfer: begin
			op0_next = regs0;
			op1_next = word_bits'(insn[7:0]);
		end
		default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			insn_valid <= 1'b0;
			op_valid <= 1'b0;
			op0 <= '0;
			op1 <= '0;
			op2 <= '0;
			carry <= 1'b0;
			op_class <= cls_alu;
		end else if (hold) begin
			op_valid <= 1'b0;
		end else begin
			insn_valid <= pop;
			op_valid <= insn_valid;
			if (insn_valid) begin
				op0 <= op0_next;
				op1 <= op1_next;
				op2 <= op2_next;
				carry <= carry_next;
				op_class <= cls;
			end
		end
	end

endmodule

`default_nettype wire

//--- decode_top.sv
`timescale 1ns/100ps
`default_nettype none

module decode_top (
	input wire clk,
	input wire rst_n,
	input wire insn_strobe,
	input wire [arm_core_pkg::word_bits-1:0] insn_word,
	output wire queue_full,
	input wire hold,
	input wire cpsr_carry,
	input wire wb_strobe,
	input wire [arm_core_pkg::reg_addr_bits-1:0] wb_addr,
	input wire [arm_core_pkg::word_bits-1:0] wb_data,
	output wire [arm_core_pkg::word_bits-1:0] op0,
	output wire [arm_core_pkg::word_bits-1:0] op1,
	output wire [arm_core_pkg::word_bits-1:0] op2,
	output wire carry,
	output wire arm_isa_pkg::insn_class_t op_class,
	output wire op_valid
);
	import arm_core_pkg::*;
	import arm_isa_pkg::*;

	wire push;
	wire [word_bits-1:0] push_insn;
	wire [word_bits-1:0] push_pc;
	wire pop;
	wire [word_bits-1:0] head_insn;
	wire [word_bits-1:0] head_pc;
	wire queue_empty;
	wire [reg_addr_bits-1:0] read_0;
	wire [reg_addr_bits-1:0] read_1;
	wire [reg_addr_bits-1:0] read_2;
	wire [word_bits-1:0] rdata_0;
	wire [word_bits-1:0] rdata_1;
	wire [word_bits-1:0] rdata_2;
	wire insn_word_u shift_insn;
	wire [word_bits-1:0] shift_operand;
	wire [word_bits-1:0] shift_amt;
	wire [word_bits-1:0] shift_result;
	wire shift_carry;

	// port names match the nets above
	pc_sequencer i_pc_sequencer (.*);
	insn_queue i_insn_queue (.*);
	register_file i_register_file (.*);
	operand_decode i_operand_decode (.*);

	operand_shifter i_operand_shifter (
		.insn(shift_insn),
		.operand(shift_operand),
		.reg_amt(shift_amt),
		.carry_in(cpsr_carry),
		.result(shift_result),
		.carry_out(shift_carry)
	);

endmodule

`default_nettype wire

//--- tb_decode_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_decode_top;
	import arm_core_pkg::*;
	import arm_isa_pkg::*;

	typedef struct {
		logic [word_bits-1:0] word;
		logic c_in;
		int pc_off;
		logic [word_bits-1:0] op0;
		logic [word_bits-1:0] op1;
		logic [word_bits-1:0] op2;
		logic carry;
		insn_class_t cls;
	} entry_t;

	logic clk = 1'b0;
	logic rst_n;
	logic insn_strobe;
	logic [word_bits-1:0] insn_word;
	logic hold;
	logic cpsr_carry;
	logic wb_strobe;
	logic [reg_addr_bits-1:0] wb_addr;
	logic [word_bits-1:0] wb_data;
	wire queue_full;
	wire [word_bits-1:0] op0;
	wire [word_bits-1:0] op1;
	wire [word_bits-1:0] op2;
	wire carry;
	insn_class_t op_class;
	wire op_valid;

	entry_t tbl[$];
	int accepted = 0;
	logic [31:0] lcg_state = 32'd53;

	decode_top i_decode_top (
		.clk(clk), .rst_n(rst_n), .insn_strobe(insn_strobe), .insn_word(insn_word),
		.queue_full(queue_full), .hold(hold), .cpsr_carry(cpsr_carry),
		.wb_strobe(wb_strobe), .wb_addr(wb_addr), .wb_data(wb_data),
		.op0(op0), .op1(op1), .op2(op2), .carry(carry),
		.op_class(op_class), .op_valid(op_valid)
	);

	always #5 clk = ~clk;

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("Testbench failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_word(input string name, input logic [word_bits-1:0] got,
			input logic [word_bits-1:0] exp);
		if (got !== exp) begin
			stop_on_error($sformatf("Mismatch at %0t: %s got %h expected %h",
				$time, name, got, exp));
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			stop_on_error($sformatf("Mismatch at %0t: %s got %b expected %b",
				$time, name, got, exp));
		end
	endtask

	task automatic check_class(input string name, input insn_class_t got,
			input insn_class_t exp);
		if (got !== exp) begin
			stop_on_error($sformatf("Mismatch at %0t: %s got %s expected %s",
				$time, name, got.name(), exp.name()));
		end
	endtask

	task automatic add(input logic [31:0] w, input logic c, input int off,
			input logic [31:0] e0, input logic [31:0] e1, input logic [31:0] e2,
			input logic ec, input insn_class_t cls);
		entry_t e;
		e.word = w;
		e.c_in = c;
		e.pc_off = off;
		e.op0 = e0;
		e.op1 = e1;
		e.op2 = e2;
		e.carry = ec;
		e.cls = cls;
		tbl.push_back(e);
	endtask

	// k is the index of the accepted word, which fixes its stamped PC
	task automatic check_result(input int idx, input int k);
		logic [word_bits-1:0] exp0;
		exp0 = tbl[idx].op0;
		if (tbl[idx].pc_off != 0) begin
			exp0 = 32'(4 * k + 8 - tbl[idx].pc_off);
		end
		check_word("op0", op0, exp0);
		check_word("op1", op1, tbl[idx].op1);
		check_word("op2", op2, tbl[idx].op2);
		check_bit("carry", carry, tbl[idx].carry);
		check_class("op_class", op_class, tbl[idx].cls);
	endtask

	// op_valid must follow a word into an idle stage by exactly two cycles
	task automatic run_single(input int idx);
		logic [word_bits-1:0] cpsr;
		int cnt;
		cpsr = 32'(tbl[idx].c_in) << cpsr_c_bit;
		@(posedge clk);
		insn_strobe <= 1'b1;
		insn_word <= tbl[idx].word;
		cpsr_carry <= cpsr[cpsr_c_bit];
		@(posedge clk);
		insn_strobe <= 1'b0;
		cnt = 0;
		do begin
			@(negedge clk);
			cnt++;
		end while (!op_valid && cnt < 20);
		if (!op_valid) begin
			stop_on_error("timeout waiting for op_valid on a single word");
		end
		check_word("latency", 32'(cnt - 1), 32'd2);
		check_result(idx, accepted);
		accepted++;
	endtask

	// fill the queue under hold, drop one word, then drain with random hold
	task automatic run_random();
		int list[$];
		int kq[$];
		int sent;
		int got;
		int cycles;
		bit full_seen;
		bit junk_done;
		bit strobed;
		logic [31:0] r;
		sent = 0;
		got = 0;
		cycles = 0;
		junk_done = 0;
		strobed = 0;
		foreach (tbl[i]) begin
			if (tbl[i].c_in) begin
				list.push_back(i);
			end
		end
		@(posedge clk);
		hold <= 1'b1;
		cpsr_carry <= 1'b1;
		while (got < list.size()) begin
			@(negedge clk);
			if (op_valid) begin
				check_result(list[got], kq.pop_front());
				got++;
			end
			full_seen = queue_full;
			@(posedge clk);
			cycles++;
			if (cycles > 400) begin
				stop_on_error("timeout waiting for results with random hold");
			end
			r = next_random();
			hold <= junk_done ? r[16] : 1'b1;
			insn_strobe <= 1'b0;
			// strobes go out every other cycle so queue_full is never a push behind
			if (!junk_done && full_seen) begin
				if (sent != queue_depth) begin
					stop_on_error("queue_full rose at the wrong fill level");
				end
				insn_strobe <= 1'b1;
				insn_word <= 32'hE3A00000;
				junk_done = 1;
			end else if (sent < list.size() && !full_seen && !strobed) begin
				insn_strobe <= 1'b1;
				insn_word <= tbl[list[sent]].word;
				kq.push_back(accepted);
				accepted++;
				sent++;
				strobed = 1;
			end else begin
				strobed = 0;
			end
		end
		hold <= 1'b0;
		insn_strobe <= 1'b0;
		repeat (6) begin
			@(negedge clk);
			if (op_valid) begin
				stop_on_error("an extra result appeared after the dropped word");
			end
		end
	endtask

	initial begin
		rst_n = 1'b0;
		insn_strobe = 1'b0;
		insn_word = '0;
		hold = 1'b0;
		cpsr_carry = 1'b0;
		wb_strobe = 1'b0;
		wb_addr = '0;
		wb_data = '0;
		// word, carry in, pc offset, op0, op1, op2, carry, class
		add(32'hE28214FF, 1, 0, 32'h02020202, 32'hFF000000, 0, 1, cls_alu);
		add(32'hE0843615, 0, 0, 32'h04040404, 32'h41414140, 0, 1, cls_alu);
		add(32'hE1A02027, 1, 0, 32'h0, 32'h0, 0, 0, cls_alu);
		add(32'hE1A01379, 1, 0, 32'h0, 32'h21212121, 0, 0, cls_alu);
		add(32'hE1A00061, 1, 0, 32'h0, 32'h80808080, 0, 1, cls_alu);
		add(32'hE1A00249, 0, 0, 32'h0, 32'h00909090, 0, 1, cls_alu);
		add(32'hE28F0004, 1, 8, 32'h0, 32'h00000004, 0, 1, cls_alu);
		add(32'hE08F0211, 1, 12, 32'h0, 32'h04040404, 0, 0, cls_alu);
		add(32'hEAFFFFF8, 1, 0, 32'hFFFFFFE0, 32'h0, 0, 0, cls_branch);
		add(32'hE1D305BA, 1, 0, 32'h03030303, 32'h0000005A, 0, 0, cls_half_imm);
		add(32'hE5921123, 1, 0, 32'h02020202, 32'h00000123, 0, 1, cls_single_xfer);
		add(32'hE894800F, 1, 0, 32'h04040404, 32'h0000800F, 0, 0, cls_block_xfer);
		add(32'hED952110, 1, 0, 32'h05050505, 32'h00000010, 0, 0, cls_cop_xfer);
		add(32'hE0214392, 1, 0, 32'h04040404, 32'h02020202, 32'h03030303, 0, cls_multiply);
		add(32'hE1020091, 1, 0, 32'h02020202, 32'h01010101, 0, 0, cls_swap);
		add(32'hE12FFF13, 1, 0, 32'h03030303, 32'h0, 0, 0, cls_bx);
		add(32'hE10F0000, 1, 0, 32'h0, 32'h0, 0, 0, cls_mrs);
		add(32'hE129F005, 1, 0, 32'h05050505, 32'h0, 0, 0, cls_msr);
		add(32'hEF000042, 1, 0, 32'h0, 32'h0, 0, 0, cls_swi);
		add(32'hE6000010, 1, 0, 32'h0, 32'h0, 0, 0, cls_undefined);
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_bit("op_valid", op_valid, 1'b0);
		check_bit("queue_full", queue_full, 1'b0);
		check_word("op0", op0, '0);
		check_word("op1", op1, '0);
		check_word("op2", op2, '0);
		check_bit("carry", carry, 1'b0);
		// register n holds n copies of the byte n
		for (int n = 0; n < gpr_count; n++) begin
			@(posedge clk);
			wb_strobe <= 1'b1;
			wb_addr <= 4'(n);
			wb_data <= 32'(n) * 32'h01010101;
		end
		@(posedge clk);
		wb_strobe <= 1'b0;
		foreach (tbl[i]) begin
			run_single(i);
		end
		run_random();
		$display("Testbench passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- decode_stage.f
arm_isa_pkg.sv
arm_core_pkg.sv
pc_sequencer.sv
insn_queue.sv
register_file.sv
operand_shifter.sv
operand_decode.sv
decode_top.sv
tb_decode_top.sv

//--- run_sim.sh
#!/bin/sh
# build and run the decode stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module tb_decode_top \
	-f decode_stage.f -o tb_decode_top_sim && \
	./obj_dir/tb_decode_top_sim | tee /dev/stderr | grep -q "Testbench passed" && \
	echo "simulation PASS" || { echo "simulation FAIL"; exit 1; }
